// File: Makefile
# Verilator build and run of the decode and serial-execute testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_dec
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?=

SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard verif/*.svh)
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(SIM_ARGS)

clean:
	rm -rf $(OBJ_DIR)

// File: logic/control_unit.sv
`timescale 1ns/1ps

module control_unit (
	input  rv_dec_pkg::opcode_e opcode_i,
	input  logic [2:0]          funct3_i,
	input  logic [6:0]          funct7_i,
	output rv_dec_pkg::cs_dec_s cs_dec_o, // Controls used in decode
	output rv_dec_pkg::cs_exe_s cs_exe_o  // Controls that travel with the beats
);

	rv_dec_pkg::alu_op_e alu_op; // ALU operation named by funct3
	logic                alu_ok; // funct3 is one of add, xor, or, and
	logic                f7_sub; // funct7 of SUB
	logic                enc_ok; // Whole encoding is one of the eleven instructions

	assign f7_sub = (funct7_i == 7'b0100000);

	// funct3 selects the ALU operation for OP_IMM and OP
	always_comb begin
		alu_ok = 1'b1;
		case (funct3_i)
			3'b000:  alu_op = rv_dec_pkg::ALU_ADD;
			3'b100:  alu_op = rv_dec_pkg::ALU_XOR;
			3'b110:  alu_op = rv_dec_pkg::ALU_OR;
			3'b111:  alu_op = rv_dec_pkg::ALU_AND;
			default: begin // Shifts and compares are not in this core
				alu_op = rv_dec_pkg::ALU_ADD;
				alu_ok = 1'b0;
			end
		endcase
	end

	always_comb begin
		// Defaults decode as a NOP that never writes
		cs_dec_o = '{inst_type: rv_dec_pkg::IT_I, ser_src: rv_dec_pkg::SER_IMM,
			use_rs2: 1'b0, use_rs1: 1'b0};
		cs_exe_o = '{alu_op: rv_dec_pkg::ALU_ADD, sub: 1'b0, a_zero: 1'b0,
			rf_write: 1'b0};
		case (opcode_i)
			rv_dec_pkg::OP_IMM: begin
				cs_dec_o.use_rs1  = 1'b1;
				cs_exe_o.alu_op   = alu_op;
				cs_exe_o.rf_write = alu_ok;
			end
			rv_dec_pkg::OP: begin
				cs_dec_o.ser_src  = rv_dec_pkg::SER_REG; // b is rs2
				cs_dec_o.use_rs1  = 1'b1;
				cs_dec_o.use_rs2  = 1'b1;
				cs_exe_o.alu_op   = alu_op;
				cs_exe_o.sub      = f7_sub;
				// SUB is the only alternate funct7 kept
				cs_exe_o.rf_write = alu_ok &&
					((funct7_i == 7'b0) || (f7_sub && (funct3_i == 3'b000)));
			end
			rv_dec_pkg::LUI: begin
				cs_dec_o.inst_type = rv_dec_pkg::IT_U;
				cs_exe_o.a_zero    = 1'b1; // 0 + imm
				cs_exe_o.rf_write  = 1'b1;
			end
			rv_dec_pkg::AUIPC: begin
				cs_dec_o.inst_type = rv_dec_pkg::IT_U;
				cs_dec_o.ser_src   = rv_dec_pkg::SER_PC; // Sum formed in decode
				cs_exe_o.a_zero    = 1'b1;
				cs_exe_o.rf_write  = 1'b1;
			end
			default: ;
		endcase
	end

	// Instruction table of ADDI..ANDI, ADD..AND, SUB, LUI and AUIPC
	always_comb begin
		case (opcode_i)
			rv_dec_pkg::OP_IMM: enc_ok = funct3_i inside {3'b000, 3'b100, 3'b110, 3'b111};
			rv_dec_pkg::OP: begin
				enc_ok = ((funct7_i == 7'b0000000) &&
					(funct3_i inside {3'b000, 3'b100, 3'b110, 3'b111})) ||
					((funct7_i == 7'b0100000) && (funct3_i == 3'b000));
			end
			rv_dec_pkg::LUI:   enc_ok = 1'b1;
			rv_dec_pkg::AUIPC: enc_ok = 1'b1;
			default:           enc_ok = 1'b0; // Loads, branches and the rest
		endcase
	end

	// Only supported encodings reach the register file or retire port
	always_comb begin
		assert (cs_exe_o.rf_write == enc_ok) else $error("rf_write disagrees with encoding");
	end

endmodule

// File: logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   valid_i,     // Fetch offers an instruction
	input  rv_dec_pkg::word_t      inst_i,
	input  rv_dec_pkg::word_t      pc_i,
	output logic                   ready_o,     // Decode takes the instruction
	input  logic                   exe_ready_i, // Execute takes the beat
	output logic                   issue_valid_o,
	output rv_dec_pkg::issue_s     issue_o,
	output rv_dec_pkg::reg_idx_t   rs32_idx_o,  // 32-bit read port index
	input  rv_dec_pkg::word_t      rs32_data_i
);

	// ==================================================
	// Declarations
	// ==================================================

	typedef enum logic [1:0] {
		ST_ISSUE_FIRST,  // Lower beat pending, may stall
		ST_ISSUE_SECOND, // Upper beat pending, fetch may refill
		ST_WAIT_FETCH    // Nothing latched
	} state_e;

	state_e                state_q;
	rv_dec_pkg::word_t     inst_q;       // Instruction register
	rv_dec_pkg::word_t     pc_q;
	rv_dec_pkg::half_t     b_hi_q;       // Upper b half captured on the lower beat
	rv_dec_pkg::reg_idx_t  last_rd_q;    // rd of the last instruction issued
	logic                  last_fresh_q; // Its upper beat went out on the last edge

	rv_dec_pkg::opcode_e   opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	rv_dec_pkg::reg_idx_t  rd;
	rv_dec_pkg::reg_idx_t  rs1;
	rv_dec_pkg::reg_idx_t  rs2;
	rv_dec_pkg::cs_dec_s   cs_dec;
	rv_dec_pkg::cs_exe_s   cs_exe;
	rv_dec_pkg::word_t     imm;
	rv_dec_pkg::word_t     ser_val;      // 32-bit operand b before splitting
	logic                  raw_hit;
	logic                  stall;
	logic                  fetch_xfer;
	logic                  issue_xfer;

	// Field extraction
	assign opcode = rv_dec_pkg::opcode_e'(inst_q[6:0]);
	assign rd     = inst_q[11:7];
	assign funct3 = inst_q[14:12];
	assign rs1    = inst_q[19:15];
	assign rs2    = inst_q[24:20];
	assign funct7 = inst_q[31:25];

	control_unit control0 (
		.opcode_i (opcode),
		.funct3_i (funct3),
		.funct7_i (funct7),
		.cs_dec_o (cs_dec),
		.cs_exe_o (cs_exe)
	);

	imm_gen imm_gen0 (
		.inst_type_i (cs_dec.inst_type),
		.inst_i      (inst_q),
		.imm_o       (imm)
	);

	// ==================================================
	// Operand b and hazard
	// ==================================================

	assign rs32_idx_o = rs2; // Only rs2 needs the full word

	always_comb begin
		case (cs_dec.ser_src)
			rv_dec_pkg::SER_REG: ser_val = rs32_data_i;
			rv_dec_pkg::SER_PC:  ser_val = pc_q + imm; // AUIPC
			default:             ser_val = imm;
		endcase
	end

	// Source matches the rd written just before
	assign raw_hit = (cs_dec.use_rs1 && (rs1 == last_rd_q)) ||
		(cs_dec.use_rs2 && (rs2 == last_rd_q));
	assign stall = (state_q == ST_ISSUE_FIRST) && last_fresh_q && raw_hit; // One cycle

	assign issue_valid_o = ((state_q == ST_ISSUE_FIRST) && !stall) ||
		(state_q == ST_ISSUE_SECOND);
	assign issue_xfer = issue_valid_o && exe_ready_i;

	// Back to back on the upper transfer, open while idle
	assign ready_o = (state_q == ST_WAIT_FETCH) ||
		((state_q == ST_ISSUE_SECOND) && exe_ready_i);
	assign fetch_xfer = valid_i && ready_o;

	always_comb begin
		issue_o.cs     = cs_exe;
		issue_o.first  = (state_q == ST_ISSUE_FIRST);
		issue_o.rd     = rd;
		issue_o.rs16   = rs1;
		issue_o.b_half = (state_q == ST_ISSUE_FIRST) ? ser_val[15:0] : b_hi_q;
	end

	// ==================================================
	// Sequential
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q <= ST_WAIT_FETCH;
			inst_q  <= rv_dec_pkg::NOP_INST;
			pc_q    <= '0;
		end else begin
			if (fetch_xfer) begin
				inst_q <= inst_i;
				pc_q   <= pc_i;
			end
			case (state_q)
				ST_ISSUE_FIRST: begin
					if (issue_xfer)
						state_q <= ST_ISSUE_SECOND;
				end
				ST_ISSUE_SECOND: begin
					if (issue_xfer)
						state_q <= valid_i ? ST_ISSUE_FIRST : ST_WAIT_FETCH;
				end
				ST_WAIT_FETCH: begin
					if (valid_i)
						state_q <= ST_ISSUE_FIRST;
				end
				default: state_q <= ST_WAIT_FETCH;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state_q == ST_ISSUE_FIRST) && issue_xfer)
			b_hi_q <= ser_val[31:16]; // rs2 may be rewritten before the upper beat
	end

	// Write history for the stall
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			last_rd_q    <= '0;
			last_fresh_q <= 1'b0;
		end else begin
			last_fresh_q <= 1'b0;
			if ((state_q == ST_ISSUE_SECOND) && issue_xfer) begin
				last_rd_q    <= rd;
				last_fresh_q <= cs_exe.rf_write && (rd != '0);
			end
		end
	end

	// A held beat must not change until execute takes it
	a_issue_hold: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid_o && !exe_ready_i |=> issue_valid_o && $stable(issue_o))
		else $error("issue beat changed under back-pressure");

endmodule

// File: logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
	input  rv_dec_pkg::inst_type_e inst_type_i, // Format chosen by control_unit
	input  rv_dec_pkg::word_t      inst_i,
	output rv_dec_pkg::word_t      imm_o
);

	rv_dec_pkg::word_t imm_i; // I-type, 12 bits sign-extended
	rv_dec_pkg::word_t imm_u; // U-type, low 12 bits zero

	assign imm_i = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_u = {inst_i[31:12], 12'b0};

	always_comb begin
		case (inst_type_i)
			rv_dec_pkg::IT_I: imm_o = imm_i;
			rv_dec_pkg::IT_U: imm_o = imm_u;
			default:          imm_o = '0; // Unused encodings
		endcase
	end

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                 clk,
	input  logic                 rst_n,
	input  rv_dec_pkg::reg_idx_t rs32_idx_i,  // Decode port
	output rv_dec_pkg::word_t    rs32_data_o,
	input  rv_dec_pkg::reg_idx_t rs16_idx_i,  // Execute port
	input  logic                 rs16_upper_i,
	output rv_dec_pkg::half_t    rs16_data_o,
	input  logic                 we_i,
	input  rv_dec_pkg::reg_idx_t wr_idx_i,
	input  logic                 wr_upper_i,  // Which half is written
	input  rv_dec_pkg::half_t    wr_data_i
);

	localparam int HW = rv_dec_pkg::XLEN_HALF;

	rv_dec_pkg::word_t regs [1:31]; // x0 has no storage
	rv_dec_pkg::word_t rs16_word;

	// x0 reads as zero on both ports
	assign rs32_data_o = (rs32_idx_i == '0) ? '0 : regs[rs32_idx_i];
	assign rs16_word   = (rs16_idx_i == '0) ? '0 : regs[rs16_idx_i];
	assign rs16_data_o = rs16_upper_i ? rs16_word[2*HW-1:HW] : rs16_word[HW-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (wr_idx_i != '0)) begin // Writes to x0 dropped
			if (wr_upper_i)
				regs[wr_idx_i][2*HW-1:HW] <= wr_data_i;
			else
				regs[wr_idx_i][HW-1:0] <= wr_data_i;
		end
	end

endmodule

// File: logic/rv_dec_pkg.sv
package rv_dec_pkg;

	// ==================================================
	// Widths
	// ==================================================

	localparam int XLEN      = 32; // Architectural word
	localparam int XLEN_HALF = 16; // Execute datapath, fixed for this core

	typedef logic [XLEN-1:0]      word_t;    // Register, PC or instruction word
	typedef logic [XLEN_HALF-1:0] half_t;    // One beat on the execute path
	typedef logic [4:0]           reg_idx_t; // x0..x31

	// ==================================================
	// Encodings
	// ==================================================

	// Only the major opcodes this slice executes
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

	typedef enum logic [1:0] {
		ALU_ADD = 2'd0, // Also SUB with cs_exe_s.sub
		ALU_XOR = 2'd1,
		ALU_OR  = 2'd2,
		ALU_AND = 2'd3
	} alu_op_e;

	// 32-bit value that decode serializes into operand b
	typedef enum logic [1:0] {
		SER_IMM = 2'd0, // Sign-extended or upper immediate
		SER_REG = 2'd1, // rs2 from the 32-bit read port
		SER_PC  = 2'd2  // PC plus immediate, for AUIPC
	} ser_src_e;

	typedef enum logic [1:0] {
		IT_I = 2'd0, // inst[31:20], sign-extended
		IT_U = 2'd1  // inst[31:12] << 12
	} inst_type_e;

	// ==================================================
	// Control and transfer structs
	// ==================================================

	typedef struct packed {
		inst_type_e inst_type; // Immediate format
		ser_src_e   ser_src;   // Operand b source
		logic       use_rs2;   // rs2 read as a register
		logic       use_rs1;   // rs1 read as a register
	} cs_dec_s;

	typedef struct packed {
		alu_op_e alu_op;
		logic    sub;      // Invert b, carry-in of one on the lower beat
		logic    a_zero;   // Operand a forced to zero
		logic    rf_write; // Result goes to rd and retires
	} cs_exe_s;

	// One half-word beat from decode to execute
	typedef struct packed {
		cs_exe_s  cs;
		logic     first;  // Lower-half beat
		reg_idx_t rd;
		reg_idx_t rs16;   // Operand a register
		half_t    b_half; // Operand b for this beat
	} issue_s;

	typedef struct packed {
		reg_idx_t rd;
		word_t    data; // Full 32-bit result
	} retire_s;

	localparam word_t NOP_INST = 32'h0000_0013; // ADDI x0, x0, 0

endpackage

// File: logic/rv_dec_top.sv
`timescale 1ns/1ps

module rv_dec_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                valid_i,       // Fetch handshake
	input  rv_dec_pkg::word_t   inst_i,
	input  rv_dec_pkg::word_t   pc_i,
	output logic                ready_o,
	output logic                retire_valid_o, // Retire handshake
	output rv_dec_pkg::retire_s retire_o,
	input  logic                retire_ready_i
);

	// ==================================================
	// Internal wires
	// ==================================================

	logic                 issue_valid;
	rv_dec_pkg::issue_s   issue;
	logic                 exe_ready;
	rv_dec_pkg::reg_idx_t rs32_idx;
	rv_dec_pkg::word_t    rs32_data;
	rv_dec_pkg::reg_idx_t rs16_idx;
	logic                 rs16_upper;
	rv_dec_pkg::half_t    rs16_data;
	logic                 we;
	rv_dec_pkg::reg_idx_t wr_idx;
	logic                 wr_upper;
	rv_dec_pkg::half_t    wr_data;

	decode_unit decode0 (
		.clk           (clk),
		.rst_n         (rst_n),
		.valid_i       (valid_i),
		.inst_i        (inst_i),
		.pc_i          (pc_i),
		.ready_o       (ready_o),
		.exe_ready_i   (exe_ready),
		.issue_valid_o (issue_valid),
		.issue_o       (issue),
		.rs32_idx_o    (rs32_idx),
		.rs32_data_i   (rs32_data)
	);

	reg_file rf0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.rs32_idx_i   (rs32_idx),
		.rs32_data_o  (rs32_data),
		.rs16_idx_i   (rs16_idx),
		.rs16_upper_i (rs16_upper),
		.rs16_data_o  (rs16_data),
		.we_i         (we),
		.wr_idx_i     (wr_idx),
		.wr_upper_i   (wr_upper),
		.wr_data_i    (wr_data)
	);

	serial_alu alu0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.issue_valid_i  (issue_valid),
		.issue_i        (issue),
		.exe_ready_o    (exe_ready),
		.rs16_idx_o     (rs16_idx),
		.rs16_upper_o   (rs16_upper),
		.rs16_data_i    (rs16_data),
		.we_o           (we),
		.wr_idx_o       (wr_idx),
		.wr_upper_o     (wr_upper),
		.wr_data_o      (wr_data),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.retire_ready_i (retire_ready_i)
	);

endmodule

// File: logic/serial_alu.sv
`timescale 1ns/1ps

module serial_alu (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 issue_valid_i,
	input  rv_dec_pkg::issue_s   issue_i,
	output logic                 exe_ready_o,
	output rv_dec_pkg::reg_idx_t rs16_idx_o,
	output logic                 rs16_upper_o,
	input  rv_dec_pkg::half_t    rs16_data_i,
	output logic                 we_o,
	output rv_dec_pkg::reg_idx_t wr_idx_o,
	output logic                 wr_upper_o,
	output rv_dec_pkg::half_t    wr_data_o,
	output logic                 retire_valid_o,
	output rv_dec_pkg::retire_s  retire_o,
	input  logic                 retire_ready_i
);

	rv_dec_pkg::half_t op_a;
	rv_dec_pkg::half_t op_b;      // Inverted for SUB
	rv_dec_pkg::half_t res;
	logic [16:0]       sum;       // Carry out in the top bit
	logic              cin;
	logic              carry_q;   // Carry from the lower beat
	rv_dec_pkg::half_t lo_q;      // Lower result half
	logic              expect_upper_q;
	logic              beat_xfer;

	// A pending retire blocks all beats
	assign exe_ready_o = !(retire_valid_o && !retire_ready_i);
	assign beat_xfer   = issue_valid_i && exe_ready_o;

	assign rs16_idx_o   = issue_i.rs16;
	assign rs16_upper_o = !issue_i.first; // Same half as the beat

	assign op_a = issue_i.cs.a_zero ? '0 : rs16_data_i;
	assign op_b = issue_i.cs.sub ? ~issue_i.b_half : issue_i.b_half;
	assign cin  = issue_i.first ? issue_i.cs.sub : carry_q; // +1 completes two's complement
	assign sum  = {1'b0, op_a} + {1'b0, op_b} + 17'(cin);

	always_comb begin
		case (issue_i.cs.alu_op)
			rv_dec_pkg::ALU_XOR: res = op_a ^ op_b;
			rv_dec_pkg::ALU_OR:  res = op_a | op_b;
			rv_dec_pkg::ALU_AND: res = op_a & op_b;
			default:             res = sum[15:0];
		endcase
	end

	// Each half written at the edge that takes its beat
	assign we_o       = beat_xfer && issue_i.cs.rf_write;
	assign wr_idx_o   = issue_i.rd;
	assign wr_upper_o = !issue_i.first;
	assign wr_data_o  = res;

	always_ff @(posedge clk) begin
		if (beat_xfer && issue_i.first) begin
			carry_q <= sum[16];
			lo_q    <= res;
		end
		if (beat_xfer && !issue_i.first && issue_i.cs.rf_write)
			retire_o <= '{rd: issue_i.rd, data: {res, lo_q}};
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			retire_valid_o <= 1'b0;
			expect_upper_q <= 1'b0;
		end else begin
			if (beat_xfer && !issue_i.first && issue_i.cs.rf_write)
				retire_valid_o <= 1'b1;
			else if (retire_ready_i)
				retire_valid_o <= 1'b0; // Taken by the environment
			if (beat_xfer)
				expect_upper_q <= issue_i.first;
		end
	end

	// Upper beats only ever follow an accepted lower beat
	a_upper_after_lower: assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid_i && !issue_i.first |-> expect_upper_q)
		else $error("upper beat without lower beat");

endmodule

// File: sources.f
+incdir+verif
logic/rv_dec_pkg.sv
logic/control_unit.sv
logic/imm_gen.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/serial_alu.sv
logic/rv_dec_top.sv
verif/tb_rv_dec.sv

// File: verif/tb_rv_model.svh
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// ==================================================
// Architectural model of the RV32I subset
// ==================================================

rv_dec_pkg::word_t model_regs [32]; // x0 never written, reads zero

function automatic void model_reset();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
endfunction

// Executes one instruction in program order, returns 1 when it retires
function automatic bit model_exec(input rv_dec_pkg::word_t inst, input rv_dec_pkg::word_t pc,
	output rv_dec_pkg::retire_s ret);
	logic [6:0]           opcode;
	logic [2:0]           f3;
	logic [6:0]           f7;
	rv_dec_pkg::reg_idx_t rd;
	rv_dec_pkg::word_t    a;
	rv_dec_pkg::word_t    b;
	rv_dec_pkg::word_t    i_imm;
	rv_dec_pkg::word_t    u_imm;
	rv_dec_pkg::word_t    res;
	bit                   ok;
	opcode = inst[6:0];
	rd     = inst[11:7];
	f3     = inst[14:12];
	f7     = inst[31:25];
	a      = model_regs[inst[19:15]];
	b      = model_regs[inst[24:20]];
	i_imm  = {{20{inst[31]}}, inst[31:20]};
	u_imm  = {inst[31:12], 12'h000};
	ok     = 1'b1;
	res    = '0;
	case (opcode)
		7'b0010011: begin // Register-immediate
			case (f3)
				3'b000:  res = a + i_imm;
				3'b100:  res = a ^ i_imm;
				3'b110:  res = a | i_imm;
				3'b111:  res = a & i_imm;
				default: ok = 1'b0; // Shifts and compares
			endcase
		end
		7'b0110011: begin // Register-register
			if ((f7 == 7'b0100000) && (f3 == 3'b000))
				res = a - b;
			else if (f7 != 7'b0000000)
				ok = 1'b0;
			else begin
				case (f3)
					3'b000:  res = a + b;
					3'b100:  res = a ^ b;
					3'b110:  res = a | b;
					3'b111:  res = a & b;
					default: ok = 1'b0;
				endcase
			end
		end
		7'b0110111: res = u_imm;      // LUI
		7'b0010111: res = pc + u_imm; // AUIPC
		default:    ok = 1'b0;
	endcase
	if (ok && (rd != '0))
		model_regs[rd] = res;
	ret.rd   = rd;
	ret.data = res;
	return ok;
endfunction

`endif

// File: verif/tb_rv_dec.sv
`timescale 1ns/1ps

module tb_rv_dec;

	localparam int unsigned NUM_INST      = 400;
	localparam int unsigned FETCH_TIMEOUT = 200;  // Cycles allowed for one fetch transfer
	localparam int unsigned DRAIN_TIMEOUT = 2000; // Cycles allowed to empty the retire queue
	localparam logic [31:0] SEED          = 32'hc564_8d41;

	logic                clk = 1'b0;
	logic                rst_n;
	logic                valid_i;
	rv_dec_pkg::word_t   inst_i;
	rv_dec_pkg::word_t   pc_i;
	logic                ready_o;
	logic                retire_valid_o;
	rv_dec_pkg::retire_s retire_o;
	logic                retire_ready_i;

	rv_dec_pkg::retire_s expq [$];   // Expected retires in program order
	rv_dec_pkg::retire_s mon_exp;
	rv_dec_pkg::retire_s held;       // Retire seen waiting on the last edge
	logic                hold_q = 1'b0;
	logic [15:0]         bp_lfsr;    // Back-pressure pattern for retire_ready_i
	int unsigned         fetched = 0;

	`include "tb_rv_model.svh"

	rv_dec_top dut0 (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid_i        (valid_i),
		.inst_i         (inst_i),
		.pc_i           (pc_i),
		.ready_o        (ready_o),
		.retire_valid_o (retire_valid_o),
		.retire_o       (retire_o),
		.retire_ready_i (retire_ready_i)
	);

	always #4 clk = ~clk; // 8 ns period

	// ==================================================
	// Checking helpers
	// ==================================================

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
			$display("test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fail_run(input string what);
		$display("ERROR at %0t: %s", $time, what);
		$display("test failed");
		$fatal(1, "run aborted");
	endtask

	// ==================================================
	// Stimulus
	// ==================================================

	function automatic rv_dec_pkg::word_t encode_itype(input logic [11:0] imm,
		input rv_dec_pkg::reg_idx_t rs1, input logic [2:0] f3,
		input rv_dec_pkg::reg_idx_t rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rv_dec_pkg::word_t encode_rtype(input logic [6:0] f7,
		input rv_dec_pkg::reg_idx_t rs2, input rv_dec_pkg::reg_idx_t rs1,
		input logic [2:0] f3, input rv_dec_pkg::reg_idx_t rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// Registers limited to x0..x7 so that hazards come up often
	function automatic rv_dec_pkg::word_t random_inst();
		int unsigned          kind;
		rv_dec_pkg::reg_idx_t rd;
		rv_dec_pkg::reg_idx_t rs1;
		rv_dec_pkg::reg_idx_t rs2;
		logic [11:0]          imm12;
		logic [19:0]          imm20;
		kind  = $urandom_range(0, 12);
		rd    = 5'($urandom_range(0, 7));
		rs1   = 5'($urandom_range(0, 7));
		rs2   = 5'($urandom_range(0, 7));
		imm12 = 12'($urandom);
		imm20 = 20'($urandom);
		case (kind)
			0:  return encode_itype(imm12, rs1, 3'b000, rd, 7'b0010011); // ADDI
			1:  return encode_itype(imm12, rs1, 3'b100, rd, 7'b0010011); // XORI
			2:  return encode_itype(imm12, rs1, 3'b110, rd, 7'b0010011); // ORI
			3:  return encode_itype(imm12, rs1, 3'b111, rd, 7'b0010011); // ANDI
			4:  return encode_rtype(7'b0000000, rs2, rs1, 3'b000, rd);   // ADD
			5:  return encode_rtype(7'b0100000, rs2, rs1, 3'b000, rd);   // SUB
			6:  return encode_rtype(7'b0000000, rs2, rs1, 3'b100, rd);   // XOR
			7:  return encode_rtype(7'b0000000, rs2, rs1, 3'b110, rd);   // OR
			8:  return encode_rtype(7'b0000000, rs2, rs1, 3'b111, rd);   // AND
			9:  return {imm20, rd, 7'b0110111};                          // LUI
			10: return {imm20, rd, 7'b0010111};                          // AUIPC
			11: return encode_itype(imm12, rs1, 3'b010, rd, 7'b0000011); // LW, unsupported
			default: return encode_itype(imm12, rs1, 3'b010, rd, 7'b0010011); // SLTI, unsupported
		endcase
	endfunction

	// Offer one instruction and wait for the fetch transfer
	task automatic fetch_one(input rv_dec_pkg::word_t inst, input rv_dec_pkg::word_t pc);
		int unsigned         waited;
		rv_dec_pkg::retire_s exp;
		waited = 0;
		valid_i <= 1'b1;
		inst_i  <= inst;
		pc_i    <= pc;
		@(posedge clk);
		while (!ready_o) begin
			waited++;
			if (waited > FETCH_TIMEOUT)
				fail_run("ready_o stayed low, fetch transfer timed out");
			else
				@(posedge clk);
		end
		fetched++; // Transfer at this edge
		if (model_exec(inst, pc, exp))
			expq.push_back(exp);
	endtask

	initial begin
		int unsigned       gap;
		int unsigned       waited;
		rv_dec_pkg::word_t inst;
		rv_dec_pkg::word_t pc;
		void'($urandom(SEED));
		bp_lfsr        = 16'($urandom) | 16'h0001; // Never all zero
		rst_n          = 1'b0;
		valid_i        = 1'b0;
		inst_i         = '0;
		pc_i           = '0;
		retire_ready_i = 1'b0;
		model_reset();
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		check_eq(64'(ready_o), 64'(1), "ready_o after reset");
		check_eq(64'(retire_valid_o), 64'(0), "retire_valid_o after reset");

		for (int n = 0; n < NUM_INST; n++) begin
			gap = ($urandom_range(0, 9) < 6) ? 0 : $urandom_range(1, 3); // Mostly back to back
			if (gap != 0) begin
				valid_i <= 1'b0;
				repeat (gap) @(posedge clk);
			end
			inst = random_inst();
			pc   = $urandom & 32'hffff_fffc;
			fetch_one(inst, pc);
		end
		valid_i <= 1'b0;

		// Drain the pipeline and the retire port
		waited = 0;
		while ((expq.size() != 0) || retire_valid_o) begin
			waited++;
			if (waited > DRAIN_TIMEOUT)
				fail_run("expected retires still outstanding after drain timeout");
			else
				@(posedge clk);
		end
		repeat (4) begin
			@(posedge clk);
			check_eq(64'(retire_valid_o), 64'(0), "spurious retire after drain");
		end
		$display("test passed");
		$finish;
	end

	// ==================================================
	// Retire monitor and back-pressure
	// ==================================================

	always @(posedge clk) begin
		if (rst_n) begin
			if (hold_q) begin // Waiting retire must stay put
				check_eq(64'(retire_valid_o), 64'(1), "retire_valid_o dropped before transfer");
				check_eq(64'(retire_o), 64'(held), "retire_o changed while waiting");
			end
			hold_q = 1'b0;
			if (retire_valid_o) begin
				if (fetched == 0)
					fail_run("retire_valid_o raised before any instruction was fetched");
				else if (retire_ready_i) begin
					if (expq.size() == 0)
						fail_run("unexpected retire with no instruction outstanding");
					else begin
						mon_exp = expq.pop_front();
						check_eq(64'(retire_o.rd), 64'(mon_exp.rd), "retire rd");
						check_eq(64'(retire_o.data), 64'(mon_exp.data), "retire data");
					end
				end else begin
					hold_q = 1'b1;
					held   = retire_o;
				end
			end
			bp_lfsr = {bp_lfsr[14:0], bp_lfsr[15] ^ bp_lfsr[13] ^ bp_lfsr[12] ^ bp_lfsr[10]};
			retire_ready_i <= (bp_lfsr[1:0] != 2'b00); // Ready about 3 cycles in 4
		end
	end

endmodule
